/* source/vgpo_num_pkg.sv */
/*
 * VGPO numeric formats
 * Q8.8 velocity word plus the wider acceleration and CPI statistics types
 */
`default_nettype none

package vgpo_num_pkg;

    // Velocity word width, Q8.8 m/s
    parameter int VEL_W = 16;

    // Signed Q8.8 velocity sample
    typedef logic signed [VEL_W-1:0] velocity_t;

    // Acceleration per pulse, same Q8.8 scale
    // Wide enough for any difference of two velocities
    typedef logic signed [31:0] accel_t;

    // Running velocity sum over one CPI
    typedef logic signed [31:0] vsum_t;

    // Running sum of squares, Q16.16 per term
    typedef logic signed [63:0] vsumsq_t;

    // Samples seen in the current CPI
    typedef logic [7:0] count_t;

endpackage

`default_nettype wire

/* source/vgpo_cfg_pkg.sv */
/*
 * VGPO detector configuration
 * Default thresholds and the reason code layout
 */
`default_nettype none

package vgpo_cfg_pkg;

    // 50 m/s^2 in Q8.8
    parameter vgpo_num_pkg::velocity_t DEFAULT_MAX_ACCEL = 16'sd12800;

    // Velocity noise budget, squared Q8.8 units
    parameter logic [31:0] DEFAULT_MAX_VARIANCE = 32'd300000;

    // Reason code, 0 none, 1 accel, 2 variance, 3 both
    typedef logic [1:0] reason_t;

    // Bit positions inside reason_t
    parameter int REASON_ACCEL_BIT = 0;
    parameter int REASON_VAR_BIT   = 1;

endpackage

`default_nettype wire

/* source/accel_monitor.sv */
/*
 * Acceleration monitor
 * First difference against the previous velocity of the track,
 * threshold check and running CPI maximum of |accel|
 */
`timescale 1ns/100ps
`default_nettype none

module accel_monitor #(
    parameter int NUM_TRACKS = 4,
    localparam int TID_W = $clog2(NUM_TRACKS)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      accept,
    input  logic                      advance,
    input  logic [TID_W-1:0]          track_id,
    input  vgpo_num_pkg::velocity_t   velocity,
    input  logic                      cpi_start,
    input  vgpo_num_pkg::velocity_t   cfg_max_accel,
    output logic                      acc_valid,
    output logic [TID_W-1:0]          acc_track_id,
    output logic                      acc_exceeded,
    output vgpo_num_pkg::accel_t      acc_max
);

    // Per-track state
    vgpo_num_pkg::velocity_t prev_vel [NUM_TRACKS];
    vgpo_num_pkg::accel_t    cpi_max  [NUM_TRACKS];
    logic [NUM_TRACKS-1:0]   has_prev;

    vgpo_num_pkg::accel_t cur_accel;
    vgpo_num_pkg::accel_t cur_abs;
    vgpo_num_pkg::accel_t cur_max;
    vgpo_num_pkg::accel_t eff_max_accel;

    // Zero override selects the default limit
    assign eff_max_accel = (cfg_max_accel != '0) ?
                           vgpo_num_pkg::accel_t'(cfg_max_accel) :
                           vgpo_num_pkg::accel_t'(vgpo_cfg_pkg::DEFAULT_MAX_ACCEL);

    always_comb begin
        // First sample of a track has no reference, report zero
        if (has_prev[track_id]) begin
            cur_accel = vgpo_num_pkg::accel_t'(velocity)
                      - vgpo_num_pkg::accel_t'(prev_vel[track_id]);
        end else begin
            cur_accel = '0;
        end
        cur_abs = (cur_accel < 0) ? -cur_accel : cur_accel;
        // CPI start restarts the maximum with this sample
        if (cpi_start || (cur_abs > cpi_max[track_id])) begin
            cur_max = cur_abs;
        end else begin
            cur_max = cpi_max[track_id];
        end
    end

    // Track memory, previous velocity kept across CPIs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < NUM_TRACKS; t++) begin
                prev_vel[t] <= '0;
                cpi_max[t]  <= '0;
            end
            has_prev <= '0;
        end else if (accept) begin
            prev_vel[track_id] <= velocity;
            cpi_max[track_id]  <= cur_max;
            has_prev[track_id] <= 1'b1;
        end
    end

    // Stage 1 valid, frozen while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_valid <= 1'b0;
        end else if (advance) begin
            acc_valid <= accept;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_track_id <= track_id;
            acc_exceeded <= (cur_abs > eff_max_accel);
            acc_max      <= cur_max;
        end
    end

    // A sample taken during a stall would overwrite the frozen stage 1 result
    assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> advance)
    else $error("accel_monitor: sample accepted while the pipeline is stalled");

endmodule

`default_nettype wire

/* source/variance_monitor.sv */
/*
 * Variance monitor
 * Per-track running sum, sum of squares and count over a CPI,
 * variance threshold check on the CPI-end sample
 */
`timescale 1ns/100ps
`default_nettype none

module variance_monitor #(
    parameter int NUM_TRACKS = 4,
    localparam int TID_W = $clog2(NUM_TRACKS)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      accept,
    input  logic                      advance,
    input  logic [TID_W-1:0]          track_id,
    input  vgpo_num_pkg::velocity_t   velocity,
    input  logic                      cpi_start,
    input  logic                      cpi_end,
    input  logic [31:0]               cfg_max_variance,
    output logic                      var_exceeded
);

    // Per-track statistics
    vgpo_num_pkg::vsum_t   vel_sum   [NUM_TRACKS];
    vgpo_num_pkg::vsumsq_t vel_sumsq [NUM_TRACKS];
    vgpo_num_pkg::count_t  vel_cnt   [NUM_TRACKS];

    vgpo_num_pkg::vsum_t   vel_ext;
    vgpo_num_pkg::vsumsq_t vel_sq;
    vgpo_num_pkg::vsum_t   new_sum;
    vgpo_num_pkg::vsumsq_t new_sumsq;
    vgpo_num_pkg::count_t  new_cnt;
    vgpo_num_pkg::vsum_t   mean;
    vgpo_num_pkg::vsumsq_t mean_sq;
    vgpo_num_pkg::vsumsq_t mean_of_sq;
    vgpo_num_pkg::vsumsq_t variance;
    logic [31:0]           eff_max_variance;
    logic                  var_flag;

    assign eff_max_variance = (cfg_max_variance != '0) ?
                              cfg_max_variance : vgpo_cfg_pkg::DEFAULT_MAX_VARIANCE;

    always_comb begin
        vel_ext = vgpo_num_pkg::vsum_t'(velocity);
        vel_sq  = vgpo_num_pkg::vsumsq_t'(velocity) * vgpo_num_pkg::vsumsq_t'(velocity);
        // Sums include the current sample, start of CPI restarts them
        if (cpi_start) begin
            new_sum   = vel_ext;
            new_sumsq = vel_sq;
            new_cnt   = 8'd1;
        end else begin
            new_sum   = vel_sum[track_id] + vel_ext;
            new_sumsq = vel_sumsq[track_id] + vel_sq;
            new_cnt   = vel_cnt[track_id] + 8'd1;
        end
        mean       = '0;
        mean_sq    = '0;
        mean_of_sq = '0;
        variance   = '0;
        var_flag   = 1'b0;
        // Var = E[x^2] - E[x]^2, both divisions truncate toward zero
        if (cpi_end && (new_cnt >= 8'd2)) begin
            mean       = new_sum / vgpo_num_pkg::vsum_t'(new_cnt);
            mean_sq    = vgpo_num_pkg::vsumsq_t'(mean) * vgpo_num_pkg::vsumsq_t'(mean);
            mean_of_sq = new_sumsq / vgpo_num_pkg::vsumsq_t'(new_cnt);
            variance   = mean_of_sq - mean_sq;
            var_flag   = (variance > vgpo_num_pkg::vsumsq_t'(eff_max_variance));
        end
    end

    // Track memory
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < NUM_TRACKS; t++) begin
                vel_sum[t]   <= '0;
                vel_sumsq[t] <= '0;
                vel_cnt[t]   <= '0;
            end
        end else if (accept) begin
            vel_sum[track_id]   <= new_sum;
            vel_sumsq[track_id] <= new_sumsq;
            vel_cnt[track_id]   <= new_cnt;
        end
    end

    // Stage 1 result, aligned with the acceleration monitor
    always_ff @(posedge clk) begin
        if (advance && accept) begin
            var_exceeded <= var_flag;
        end
    end

    // A CPI end without its own start needs an open CPI on that track
    assert property (@(posedge clk) disable iff (!rst_n)
        (accept && cpi_end && !cpi_start) |-> (vel_cnt[track_id] != '0))
    else $error("variance_monitor: CPI end on a track with no open CPI");

endmodule

`default_nettype wire

/* source/verdict_merge.sv */
/*
 * Verdict merge
 * Folds both monitor flags into the registered jammer verdict
 */
`timescale 1ns/100ps
`default_nettype none

module verdict_merge #(
    parameter int NUM_TRACKS = 4,
    localparam int TID_W = $clog2(NUM_TRACKS)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      advance,
    input  logic                      acc_valid,
    input  logic                      acc_exceeded,
    input  logic [TID_W-1:0]          acc_track_id,
    input  vgpo_num_pkg::accel_t      acc_max,
    input  logic                      var_exceeded,
    output logic                      jammer_valid,
    output logic                      jammer_detected,
    output logic [TID_W-1:0]          jammer_track_id,
    output vgpo_cfg_pkg::reason_t     jammer_reason,
    output vgpo_num_pkg::accel_t      jammer_max_accel
);

    vgpo_cfg_pkg::reason_t reason;

    always_comb begin
        reason = '0;
        reason[vgpo_cfg_pkg::REASON_ACCEL_BIT] = acc_exceeded;
        reason[vgpo_cfg_pkg::REASON_VAR_BIT]   = var_exceeded;
    end

    // Output valid, held while the consumer stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jammer_valid <= 1'b0;
        end else if (advance) begin
            jammer_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && acc_valid) begin
            jammer_track_id  <= acc_track_id;
            jammer_detected  <= |reason;
            jammer_reason    <= reason;
            jammer_max_accel <= acc_max;
        end
    end

    // Stalled stage 1 result from both monitors must wait unchanged
    assert property (@(posedge clk) disable iff (!rst_n)
        (acc_valid && !advance) |=> (acc_valid && $stable(acc_track_id)
            && $stable(acc_exceeded) && $stable(acc_max)
            && $stable(var_exceeded)))
    else $error("verdict_merge: stage 1 result changed while stalled");

endmodule

`default_nettype wire

/* source/vgpo_detector_top.sv */
/*
 * VGPO detector top level
 * Input handshake, pipeline stall and the two monitors feeding the merge
 */
`timescale 1ns/100ps
`default_nettype none

module vgpo_detector_top #(
    parameter int NUM_TRACKS = 4,
    localparam int TID_W = $clog2(NUM_TRACKS)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // Velocity stream
    input  logic                      velocity_valid,
    input  logic [TID_W-1:0]          velocity_track_id,
    input  vgpo_num_pkg::velocity_t   velocity_data,
    input  logic                      velocity_cpi_start,
    input  logic                      velocity_cpi_end,
    output logic                      velocity_ready,
    // Jammer verdicts
    output logic                      jammer_valid,
    input  logic                      jammer_ready,
    output logic [TID_W-1:0]          jammer_track_id,
    output logic                      jammer_detected,
    output vgpo_cfg_pkg::reason_t     jammer_reason,
    output vgpo_num_pkg::accel_t      jammer_max_accel,
    // Configuration, zero thresholds pick the defaults
    input  logic                      cfg_enable,
    input  vgpo_num_pkg::velocity_t   cfg_max_accel,
    input  logic [31:0]               cfg_max_variance
);

    logic                 accept;
    logic                 advance;
    logic                 acc_valid;
    logic [TID_W-1:0]     acc_track_id;
    logic                 acc_exceeded;
    vgpo_num_pkg::accel_t acc_max;
    logic                 var_exceeded;

    // Whole pipeline moves only when the output slot is free or drained
    assign advance        = !jammer_valid || jammer_ready;
    assign velocity_ready = cfg_enable && advance;
    assign accept         = velocity_valid && velocity_ready;

    accel_monitor #(.NUM_TRACKS(NUM_TRACKS)) u_accel (
        .clk           (clk),
        .rst_n         (rst_n),
        .accept        (accept),
        .advance       (advance),
        .track_id      (velocity_track_id),
        .velocity      (velocity_data),
        .cpi_start     (velocity_cpi_start),
        .cfg_max_accel (cfg_max_accel),
        .acc_valid     (acc_valid),
        .acc_track_id  (acc_track_id),
        .acc_exceeded  (acc_exceeded),
        .acc_max       (acc_max)
    );

    variance_monitor #(.NUM_TRACKS(NUM_TRACKS)) u_var (
        .clk              (clk),
        .rst_n            (rst_n),
        .accept           (accept),
        .advance          (advance),
        .track_id         (velocity_track_id),
        .velocity         (velocity_data),
        .cpi_start        (velocity_cpi_start),
        .cpi_end          (velocity_cpi_end),
        .cfg_max_variance (cfg_max_variance),
        .var_exceeded     (var_exceeded)
    );

    // Both monitors load on the same accept, acc_valid qualifies both
    verdict_merge #(.NUM_TRACKS(NUM_TRACKS)) u_merge (
        .clk              (clk),
        .rst_n            (rst_n),
        .advance          (advance),
        .acc_valid        (acc_valid),
        .acc_exceeded     (acc_exceeded),
        .acc_track_id     (acc_track_id),
        .acc_max          (acc_max),
        .var_exceeded     (var_exceeded),
        .jammer_valid     (jammer_valid),
        .jammer_detected  (jammer_detected),
        .jammer_track_id  (jammer_track_id),
        .jammer_reason    (jammer_reason),
        .jammer_max_accel (jammer_max_accel)
    );

endmodule

`default_nettype wire

/* verification/vgpo_detector_tb.sv */
/*
 * VGPO detector testbench
 * Directed tests against a reference model of the acceleration and
 * variance rules, verdicts checked in order at the output handshake
 */
`timescale 1ns/100ps
`default_nettype none

module vgpo_detector_tb;

    localparam int NUM_TRACKS   = 4;
    localparam int TID_W        = $clog2(NUM_TRACKS);
    localparam int CLK_PERIOD   = 4;
    // Samples sent over all tests, with room for stalls and drains
    localparam int NUM_SAMPLES  = 64;
    localparam int STALL_MARGIN = 16;
    localparam int TIMEOUT_NS   = (NUM_SAMPLES * STALL_MARGIN + 100) * CLK_PERIOD;

    logic                    clk;
    logic                    rst_n;
    logic                    velocity_valid;
    logic [TID_W-1:0]        velocity_track_id;
    vgpo_num_pkg::velocity_t velocity_data;
    logic                    velocity_cpi_start;
    logic                    velocity_cpi_end;
    logic                    velocity_ready;
    logic                    jammer_valid;
    logic                    jammer_ready;
    logic [TID_W-1:0]        jammer_track_id;
    logic                    jammer_detected;
    vgpo_cfg_pkg::reason_t   jammer_reason;
    vgpo_num_pkg::accel_t    jammer_max_accel;
    logic                    cfg_enable;
    vgpo_num_pkg::velocity_t cfg_max_accel;
    logic [31:0]             cfg_max_variance;

    integer seed;
    logic   bp_mode;

    // Reference model state per track
    longint m_prev  [NUM_TRACKS];
    bit     m_has   [NUM_TRACKS];
    longint m_max   [NUM_TRACKS];
    longint m_sum   [NUM_TRACKS];
    longint m_sumsq [NUM_TRACKS];
    longint m_cnt   [NUM_TRACKS];

    // Expected verdicts in acceptance order
    longint exp_tid    [$];
    longint exp_det    [$];
    longint exp_reason [$];
    longint exp_max    [$];

    // Last stalled verdict
    logic                held;
    logic signed [63:0]  held_tid;
    logic signed [63:0]  held_det;
    logic signed [63:0]  held_reason;
    logic signed [63:0]  held_max;

    vgpo_detector_top #(.NUM_TRACKS(NUM_TRACKS)) dut_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .velocity_valid     (velocity_valid),
        .velocity_track_id  (velocity_track_id),
        .velocity_data      (velocity_data),
        .velocity_cpi_start (velocity_cpi_start),
        .velocity_cpi_end   (velocity_cpi_end),
        .velocity_ready     (velocity_ready),
        .jammer_valid       (jammer_valid),
        .jammer_ready       (jammer_ready),
        .jammer_track_id    (jammer_track_id),
        .jammer_detected    (jammer_detected),
        .jammer_reason      (jammer_reason),
        .jammer_max_accel   (jammer_max_accel),
        .cfg_enable         (cfg_enable),
        .cfg_max_accel      (cfg_max_accel),
        .cfg_max_variance   (cfg_max_variance)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic signed [63:0] got,
                               input logic signed [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Drive one sample, wait for it to be taken and predict its verdict
    task automatic send_sample(input int tid, input int vel, input bit start, input bit last);
        longint acc;
        longint abs_acc;
        longint thr_a;
        longint thr_v;
        longint variance;
        bit     flag_a;
        bit     flag_v;
        @(negedge clk);
        velocity_valid     = 1'b1;
        velocity_track_id  = TID_W'(tid);
        velocity_data      = vgpo_num_pkg::velocity_t'(vel);
        velocity_cpi_start = start;
        velocity_cpi_end   = last;
        #1;
        while (!velocity_ready) begin
            @(negedge clk);
            #1;
        end
        thr_a = (cfg_max_accel == 0) ? longint'(vgpo_cfg_pkg::DEFAULT_MAX_ACCEL) :
                                       longint'(cfg_max_accel);
        thr_v = (cfg_max_variance == 0) ? longint'(vgpo_cfg_pkg::DEFAULT_MAX_VARIANCE) :
                                          longint'(cfg_max_variance);
        // First difference, zero until the track has a reference
        acc = m_has[tid] ? longint'(vel) - m_prev[tid] : 0;
        abs_acc = (acc < 0) ? -acc : acc;
        if (start || abs_acc > m_max[tid]) begin
            m_max[tid] = abs_acc;
        end
        m_prev[tid] = vel;
        m_has[tid]  = 1'b1;
        flag_a = abs_acc > thr_a;
        // CPI statistics including this sample
        if (start) begin
            m_sum[tid]   = vel;
            m_sumsq[tid] = longint'(vel) * vel;
            m_cnt[tid]   = 1;
        end else begin
            m_sum[tid]   = m_sum[tid] + vel;
            m_sumsq[tid] = m_sumsq[tid] + longint'(vel) * vel;
            m_cnt[tid]   = m_cnt[tid] + 1;
        end
        flag_v = 1'b0;
        if (last && m_cnt[tid] >= 2) begin
            variance = m_sumsq[tid] / m_cnt[tid]
                     - (m_sum[tid] / m_cnt[tid]) * (m_sum[tid] / m_cnt[tid]);
            flag_v = variance > thr_v;
        end
        exp_tid.push_back(tid);
        exp_det.push_back(longint'(flag_a || flag_v));
        exp_reason.push_back(longint'({flag_v, flag_a}));
        exp_max.push_back(m_max[tid]);
        @(posedge clk);
    endtask

    // Stop the stream and wait for every outstanding verdict
    task automatic drain_verdicts();
        @(negedge clk);
        velocity_valid = 1'b0;
        while (exp_tid.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic reset_and_enable();
        check_value("jammer_valid", 64'(jammer_valid), 64'd0);
        @(negedge clk);
        cfg_enable        = 1'b0;
        velocity_valid    = 1'b1;
        velocity_track_id = '0;
        velocity_data     = 16'sd1000;
        repeat (6) begin
            @(negedge clk);
            #1;
            check_value("velocity_ready", 64'(velocity_ready), 64'd0);
            check_value("jammer_valid", 64'(jammer_valid), 64'd0);
        end
        @(negedge clk);
        velocity_valid = 1'b0;
        cfg_enable     = 1'b1;
        #1;
        check_value("velocity_ready", 64'(velocity_ready), 64'd1);
    endtask

    task automatic steady_track();
        for (int i = 0; i < 6; i++) begin
            send_sample(0, 2560, i == 0, i == 5);
        end
        drain_verdicts();
    endtask

    task automatic accel_step();
        // Default limit, 14000 step
        send_sample(1, 1000, 1'b1, 1'b0);
        send_sample(1, 1000, 1'b0, 1'b0);
        send_sample(1, 15000, 1'b0, 1'b0);
        send_sample(1, 15000, 1'b0, 1'b1);
        drain_verdicts();
        @(negedge clk);
        cfg_max_accel = 16'sd1000;
        send_sample(2, 500, 1'b1, 1'b0);
        send_sample(2, 2000, 1'b0, 1'b0);
        send_sample(2, 2100, 1'b0, 1'b1);
        drain_verdicts();
        @(negedge clk);
        cfg_max_accel = '0;
        // One LSB under the default limit
        send_sample(1, 15000, 1'b1, 1'b0);
        send_sample(1, 27799, 1'b0, 1'b1);
        drain_verdicts();
    endtask

    task automatic variance_spread();
        @(negedge clk);
        cfg_max_accel = 16'sh7fff;
        send_sample(3, 1000, 1'b1, 1'b0);
        send_sample(3, -1000, 1'b0, 1'b0);
        send_sample(3, 1000, 1'b0, 1'b0);
        send_sample(3, -1000, 1'b0, 1'b1);
        drain_verdicts();
        @(negedge clk);
        cfg_max_accel = '0;
        // Large steps and large spread together
        send_sample(0, 0, 1'b1, 1'b0);
        send_sample(0, 20000, 1'b0, 1'b0);
        send_sample(0, 0, 1'b0, 1'b0);
        send_sample(0, 20000, 1'b0, 1'b1);
        drain_verdicts();
    endtask

    task automatic interleaved_tracks();
        for (int r = 0; r < 4; r++) begin
            for (int t = 0; t < NUM_TRACKS; t++) begin
                send_sample(t, $random(seed) % 16000, r == 0, r == 3);
            end
        end
        drain_verdicts();
    endtask

    task automatic back_pressure();
        // Mode changes away from the falling edge where the consumer draws
        @(posedge clk);
        bp_mode = 1'b1;
        for (int r = 0; r < 6; r++) begin
            for (int t = 0; t < NUM_TRACKS; t++) begin
                send_sample(t, $random(seed) % 8000, r == 0, r == 5);
            end
        end
        drain_verdicts();
        @(posedge clk);
        bp_mode = 1'b0;
    endtask

    // Output consumer, random stalls only in back-pressure mode
    initial begin
        jammer_ready = 1'b1;
        forever begin
            @(negedge clk);
            jammer_ready = bp_mode ? 1'($random(seed)) : 1'b1;
        end
    end

    // Verdict checker, sampled mid-cycle where the handshake is stable
    initial begin
        held = 1'b0;
        forever begin
            @(negedge clk);
            #1;
            if (held) begin
                check_value("jammer_valid", 64'(jammer_valid), 64'd1);
                check_value("jammer_track_id", 64'(jammer_track_id), held_tid);
                check_value("jammer_detected", 64'(jammer_detected), held_det);
                check_value("jammer_reason", 64'(jammer_reason), held_reason);
                check_value("jammer_max_accel", 64'(jammer_max_accel), held_max);
            end
            if (jammer_valid && jammer_ready) begin
                if (exp_tid.size() == 0) begin
                    $display("Unexpected verdict for track %0d with no sample outstanding",
                             jammer_track_id);
                    $display("SIMULATION FAILED");
                    $fatal(1, "extra verdict");
                end else begin
                    check_value("jammer_track_id", 64'(jammer_track_id),
                                exp_tid.pop_front());
                    check_value("jammer_detected", 64'(jammer_detected),
                                exp_det.pop_front());
                    check_value("jammer_reason", 64'(jammer_reason),
                                exp_reason.pop_front());
                    check_value("jammer_max_accel", 64'(jammer_max_accel),
                                exp_max.pop_front());
                end
            end
            held        = jammer_valid && !jammer_ready;
            held_tid    = 64'(jammer_track_id);
            held_det    = 64'(jammer_detected);
            held_reason = 64'(jammer_reason);
            held_max    = 64'(jammer_max_accel);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, %0d verdicts still outstanding",
                 TIMEOUT_NS, exp_tid.size());
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed               = 32'ha98a_1f28;
        bp_mode            = 1'b0;
        rst_n              = 1'b0;
        velocity_valid     = 1'b0;
        velocity_track_id  = '0;
        velocity_data      = '0;
        velocity_cpi_start = 1'b0;
        velocity_cpi_end   = 1'b0;
        cfg_enable         = 1'b1;
        cfg_max_accel      = '0;
        cfg_max_variance   = '0;
        for (int t = 0; t < NUM_TRACKS; t++) begin
            m_prev[t]  = 0;
            m_has[t]   = 1'b0;
            m_max[t]   = 0;
            m_sum[t]   = 0;
            m_sumsq[t] = 0;
            m_cnt[t]   = 0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_and_enable();
        steady_track();
        accel_step();
        variance_spread();
        interleaved_tracks();
        back_pressure();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vgpo_detector.f */
source/vgpo_num_pkg.sv
source/vgpo_cfg_pkg.sv
source/accel_monitor.sv
source/variance_monitor.sv
source/verdict_merge.sv
source/vgpo_detector_top.sv
verification/vgpo_detector_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the VGPO detector testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module vgpo_detector_tb \
    -f vgpo_detector.f \
    --Mdir obj_dir -o vgpo_sim

status=0
./obj_dir/vgpo_sim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if [ "$status" -eq 0 ] && grep -qx "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
exit 1
